/* common/mam_pkg.sv */
// Shared widths, address map and bus structs that every file of the memory access path references by scoped name
package mam_pkg;

   // Data and address widths
   localparam int unsigned DATA_WIDTH  = 16;
   localparam int unsigned ADDR_WIDTH  = 32;
   localparam int unsigned SEL_WIDTH   = DATA_WIDTH / 8;
   localparam int unsigned BEATS_WIDTH = 14;         // Burst length counter

   // Bank geometry
   localparam int unsigned NUM_BANKS      = 4;
   localparam int unsigned BANK_WORDS     = 64;
   localparam int unsigned OFFSET_LSB     = $clog2(SEL_WIDTH);          // Byte lane bits skipped
   localparam int unsigned OFFSET_WIDTH   = $clog2(BANK_WORDS);         // Word offset, bits 6..1
   localparam int unsigned BANK_IDX_LSB   = OFFSET_LSB + OFFSET_WIDTH;  // Bank index, bits 8..7
   localparam int unsigned BANK_IDX_WIDTH = $clog2(NUM_BANKS);

   // Everything from here upwards is answered by the merger
   localparam logic [ADDR_WIDTH-1:0] MAPPED_LIMIT  = 32'h0000_0200;
   localparam logic [DATA_WIDTH-1:0] UNMAPPED_DATA = 16'hDEAD;

   // Wishbone cycle type and burst type
   localparam logic [2:0] CTI_CLASSIC = 3'b000;
   localparam logic [2:0] CTI_INCR    = 3'b010;
   localparam logic [2:0] CTI_END     = 3'b111;
   localparam logic [1:0] BTE_LINEAR  = 2'b00;       // Only linear bursts

   // One memory access request
   typedef struct packed {
      logic                   we;                    // 1 write, 0 read
      logic [ADDR_WIDTH-1:0]  addr;                  // Byte address of first beat
      logic                   burst;                 // Incrementing burst when set
      logic [BEATS_WIDTH-1:0] beats;                 // Words in a burst
   } mam_req_t;

   // Wishbone request with cyc equal to stb
   typedef struct packed {
      logic                  stb;
      logic                  we;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] dat;
      logic [SEL_WIDTH-1:0]  sel;
      logic [2:0]            cti;
      logic [1:0]            bte;
   } wb_req_t;

   // Wishbone response
   typedef struct packed {
      logic                  ack;
      logic [DATA_WIDTH-1:0] dat;
   } wb_rsp_t;

endpackage

/* wb_mem/wb_bank_decoder.sv */
// Address decoder that steers one Wishbone request to its bank and flags unmapped accesses
`timescale 1ns/1ps

module wb_bank_decoder (
   input  mam_pkg::wb_req_t                           wb_req_i,
   output mam_pkg::wb_req_t [mam_pkg::NUM_BANKS-1:0]  bank_req_o,
   output logic                                       miss_o
);

   logic                                 mapped;
   logic [mam_pkg::BANK_IDX_WIDTH-1:0]   bank_idx;

   // Each beat is decoded on its own so bursts may cross banks
   assign mapped   = (wb_req_i.addr < mam_pkg::MAPPED_LIMIT);
   assign bank_idx = wb_req_i.addr[mam_pkg::BANK_IDX_LSB +: mam_pkg::BANK_IDX_WIDTH];

   assign miss_o = wb_req_i.stb && !mapped;  // Answered by the merger

   always_comb begin
      for (int b = 0; b < mam_pkg::NUM_BANKS; b++) begin
         bank_req_o[b]     = wb_req_i;       // Fields shared by all banks
         bank_req_o[b].stb = wb_req_i.stb && mapped &&
                             (bank_idx == b[mam_pkg::BANK_IDX_WIDTH-1:0]);
      end
   end

endmodule

/* wb_mem/wb_sram_bank.sv */
// Word-addressed SRAM bank on Wishbone that the memory top level instantiates once per bank
`timescale 1ns/1ps

module wb_sram_bank (
   input  logic             clk_i,
   input  logic             rst_i,
   input  mam_pkg::wb_req_t bank_req_i,
   output mam_pkg::wb_rsp_t bank_rsp_o
);

   logic [mam_pkg::DATA_WIDTH-1:0]   mem_q [mam_pkg::BANK_WORDS];
   logic [mam_pkg::OFFSET_WIDTH-1:0] word_idx;
   logic [mam_pkg::DATA_WIDTH-1:0]   rdat_q;
   logic                             ack_q;
   logic                             access;

   assign word_idx = bank_req_i.addr[mam_pkg::OFFSET_LSB +: mam_pkg::OFFSET_WIDTH];

   // Master still holds stb during the ack cycle, so skip that one
   assign access = bank_req_i.stb && !ack_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;                    // One cycle after stb
      end
   end

   // Byte lane writes
   always_ff @(posedge clk_i) begin
      if (access && bank_req_i.we) begin
         for (int b = 0; b < mam_pkg::SEL_WIDTH; b++) begin
            if (bank_req_i.sel[b]) begin
               mem_q[word_idx][8*b +: 8] <= bank_req_i.dat[8*b +: 8];
            end
         end
      end
   end

   // Registered read, lines up with ack
   always_ff @(posedge clk_i) begin
      if (access) begin
         rdat_q <= mem_q[word_idx];
      end
   end

   always_comb begin
      bank_rsp_o.ack = ack_q;
      bank_rsp_o.dat = rdat_q;
   end

endmodule

/* wb_mem/wb_resp_merge.sv */
// Response merger that forwards the acknowledging bank and answers unmapped beats with filler data
`timescale 1ns/1ps

module wb_resp_merge (
   input  logic                                       clk_i,
   input  logic                                       rst_i,
   input  mam_pkg::wb_rsp_t [mam_pkg::NUM_BANKS-1:0]  bank_rsp_i,
   input  logic                                       miss_i,
   output mam_pkg::wb_rsp_t                           wb_rsp_o
);

   logic miss_ack_q;

   // Same single-ack rule as the banks
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         miss_ack_q <= 1'b0;
      end else begin
         miss_ack_q <= miss_i && !miss_ack_q;
      end
   end

   always_comb begin
      wb_rsp_o.ack = miss_ack_q;
      wb_rsp_o.dat = miss_ack_q ? mam_pkg::UNMAPPED_DATA : '0;  // Writes there are dropped
      // At most one bank acks per beat
      for (int b = 0; b < mam_pkg::NUM_BANKS; b++) begin
         if (bank_rsp_i[b].ack) begin
            wb_rsp_o.ack = 1'b1;
            wb_rsp_o.dat = bank_rsp_i[b].dat;
         end
      end
   end

endmodule

/* hw/mam_wb_master.sv */
// Wishbone master that turns memory access requests and the write/read streams into bus beats
`timescale 1ns/1ps

module mam_wb_master (
   input  logic                           clk_i,
   input  logic                           rst_i,

   input  logic                           req_valid_i,
   input  mam_pkg::mam_req_t              req_i,
   output logic                           req_ready_o,

   input  logic                           wr_valid_i,
   input  logic [mam_pkg::DATA_WIDTH-1:0] wr_data_i,
   input  logic [mam_pkg::SEL_WIDTH-1:0]  wr_strb_i,
   output logic                           wr_ready_o,

   output logic                           rd_valid_o,
   output logic [mam_pkg::DATA_WIDTH-1:0] rd_data_o,
   input  logic                           rd_ready_i,

   output mam_pkg::wb_req_t               wb_req_o,
   input  mam_pkg::wb_rsp_t               wb_rsp_i
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITE_WAIT,
      ST_WRITE,
      ST_WRITE_LAST_WAIT,
      ST_WRITE_LAST,
      ST_READ,
      ST_READ_WAIT
   } state_t;

   state_t state_q, state_d;

   logic [mam_pkg::ADDR_WIDTH-1:0]  addr_q, addr_d;    // Running beat address
   logic [mam_pkg::BEATS_WIDTH-1:0] beats_q, beats_d;  // Beats still to finish
   logic                            we_q, we_d;
   logic                            burst_q, burst_d;
   logic [2:0]                      cti_q, cti_d;
   logic [mam_pkg::DATA_WIDTH-1:0]  wdat_q, wdat_d;
   logic [mam_pkg::SEL_WIDTH-1:0]   sel_q, sel_d;
   logic [mam_pkg::DATA_WIDTH-1:0]  rdat_q, rdat_d;

   logic stb;
   logic req_last;       // Request is a single beat
   logic next_is_last;   // Write beat after the current one ends the burst

   assign req_last     = !req_i.burst || (req_i.beats <= 1);
   assign next_is_last = (beats_q == 2);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Payload registers
   always_ff @(posedge clk_i) begin
      addr_q  <= addr_d;
      beats_q <= beats_d;
      we_q    <= we_d;
      burst_q <= burst_d;
      cti_q   <= cti_d;
      wdat_q  <= wdat_d;
      sel_q   <= sel_d;
      rdat_q  <= rdat_d;
   end

   always_comb begin
      state_d = state_q;
      addr_d  = addr_q;
      beats_d = beats_q;
      we_d    = we_q;
      burst_d = burst_q;
      cti_d   = cti_q;
      wdat_d  = wdat_q;
      sel_d   = sel_q;
      rdat_d  = rdat_q;

      req_ready_o = 1'b0;
      wr_ready_o  = 1'b0;
      rd_valid_o  = 1'b0;
      stb         = 1'b0;

      case (state_q)
         ST_IDLE: begin
            req_ready_o = 1'b1;
            if (req_valid_i) begin
               addr_d  = req_i.addr;
               we_d    = req_i.we;
               burst_d = req_i.burst;
               beats_d = req_last ? 1 : req_i.beats;  // Zero-length burst runs one beat
               cti_d   = req_last ? mam_pkg::CTI_END : mam_pkg::CTI_INCR;
               sel_d   = '1;
               if (!req_i.we) begin
                  state_d = ST_READ;
               end else if (req_last) begin
                  state_d = ST_WRITE_LAST_WAIT;
               end else begin
                  state_d = ST_WRITE_WAIT;
               end
            end
         end
         ST_WRITE_WAIT, ST_WRITE_LAST_WAIT: begin
            wr_ready_o = 1'b1;
            if (wr_valid_i) begin
               wdat_d = wr_data_i;
               if (!burst_q) begin
                  sel_d = wr_strb_i;              // Strobes only on single writes
               end
               state_d = (state_q == ST_WRITE_WAIT) ? ST_WRITE : ST_WRITE_LAST;
            end
         end
         ST_WRITE: begin
            stb = 1'b1;
            if (wb_rsp_i.ack) begin
               wr_ready_o = 1'b1;                 // Next word taken with the ack
               addr_d  = addr_q + mam_pkg::SEL_WIDTH;
               beats_d = beats_q - 1;
               cti_d   = next_is_last ? mam_pkg::CTI_END : mam_pkg::CTI_INCR;
               if (wr_valid_i) begin
                  wdat_d  = wr_data_i;
                  state_d = next_is_last ? ST_WRITE_LAST : ST_WRITE;
               end else begin
                  state_d = next_is_last ? ST_WRITE_LAST_WAIT : ST_WRITE_WAIT;
               end
            end
         end
         ST_WRITE_LAST: begin
            stb = 1'b1;
            if (wb_rsp_i.ack) begin
               cti_d   = mam_pkg::CTI_CLASSIC;
               state_d = ST_IDLE;
            end
         end
         ST_READ: begin
            stb = 1'b1;
            if (wb_rsp_i.ack) begin
               rdat_d  = wb_rsp_i.dat;
               addr_d  = addr_q + mam_pkg::SEL_WIDTH;
               beats_d = beats_q - 1;
               state_d = ST_READ_WAIT;
            end
         end
         ST_READ_WAIT: begin
            rd_valid_o = 1'b1;                    // Held until the word is taken
            if (rd_ready_i) begin
               if (beats_q == 0) begin
                  cti_d   = mam_pkg::CTI_CLASSIC;
                  state_d = ST_IDLE;
               end else begin
                  cti_d   = (beats_q == 1) ? mam_pkg::CTI_END : mam_pkg::CTI_INCR;
                  state_d = ST_READ;
               end
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   assign rd_data_o = rdat_q;

   always_comb begin
      wb_req_o.stb  = stb;
      wb_req_o.we   = we_q;
      wb_req_o.addr = addr_q;
      wb_req_o.dat  = wdat_q;
      wb_req_o.sel  = sel_q;
      wb_req_o.cti  = cti_q;
      wb_req_o.bte  = mam_pkg::BTE_LINEAR;
   end

endmodule

/* hw/mam_mem_top.sv */
// Top level of the memory access path that joins the Wishbone master to the banked memory
`timescale 1ns/1ps

module mam_mem_top (
   input  logic                           clk_i,
   input  logic                           rst_i,

   input  logic                           req_valid_i,
   input  mam_pkg::mam_req_t              req_i,
   output logic                           req_ready_o,

   input  logic                           wr_valid_i,
   input  logic [mam_pkg::DATA_WIDTH-1:0] wr_data_i,
   input  logic [mam_pkg::SEL_WIDTH-1:0]  wr_strb_i,
   output logic                           wr_ready_o,

   output logic                           rd_valid_o,
   output logic [mam_pkg::DATA_WIDTH-1:0] rd_data_o,
   input  logic                           rd_ready_i
);

   mam_pkg::wb_req_t                          wb_req;
   mam_pkg::wb_rsp_t                          wb_rsp;
   mam_pkg::wb_req_t [mam_pkg::NUM_BANKS-1:0] bank_req;
   mam_pkg::wb_rsp_t [mam_pkg::NUM_BANKS-1:0] bank_rsp;
   logic                                      miss;     // Beat above the mapped range

   mam_wb_master i_mam_wb_master (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .req_ready_o (req_ready_o),
      .wr_valid_i  (wr_valid_i),
      .wr_data_i   (wr_data_i),
      .wr_strb_i   (wr_strb_i),
      .wr_ready_o  (wr_ready_o),
      .rd_valid_o  (rd_valid_o),
      .rd_data_o   (rd_data_o),
      .rd_ready_i  (rd_ready_i),
      .wb_req_o    (wb_req),
      .wb_rsp_i    (wb_rsp)
   );

   wb_bank_decoder i_wb_bank_decoder (
      .wb_req_i   (wb_req),
      .bank_req_o (bank_req),
      .miss_o     (miss)
   );

   for (genvar b = 0; b < mam_pkg::NUM_BANKS; b++) begin : g_bank
      wb_sram_bank i_wb_sram_bank (
         .clk_i      (clk_i),
         .rst_i      (rst_i),
         .bank_req_i (bank_req[b]),
         .bank_rsp_o (bank_rsp[b])
      );
   end

   wb_resp_merge i_wb_resp_merge (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .bank_rsp_i (bank_rsp),
      .miss_i     (miss),
      .wb_rsp_o   (wb_rsp)
   );

endmodule

/* tb/tb_clk_gen.sv */
// Free-running 40 ns testbench clock source for the memory access path
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o
);

   localparam int HALF_PERIOD_NS = 20;

   initial begin
      clk_o = 1'b0;                          // First rising edge at 20 ns
      forever #HALF_PERIOD_NS clk_o = ~clk_o;
   end

endmodule

/* tb/mam_mem_tb.sv */
// Testbench that replays tb/mam_stim.txt against mam_mem_top and a reference memory model
`timescale 1ns/1ps

module mam_mem_tb;

   localparam int CLK_PERIOD_NS       = 40;
   localparam int MAX_CYCLES_PER_BEAT = 12;   // Random gaps plus two bus cycles and some margin
   localparam int OP_OVERHEAD_CYCLES  = 8;
   localparam int SETUP_CYCLES        = 20;
   localparam int REF_WORDS           = mam_pkg::NUM_BANKS * mam_pkg::BANK_WORDS;

   logic                           clk_i;
   logic                           rst_i;
   logic                           req_valid_i;
   mam_pkg::mam_req_t              req_i;
   logic                           req_ready_o;
   logic                           wr_valid_i;
   logic [mam_pkg::DATA_WIDTH-1:0] wr_data_i;
   logic [mam_pkg::SEL_WIDTH-1:0]  wr_strb_i;
   logic                           wr_ready_o;
   logic                           rd_valid_o;
   logic [mam_pkg::DATA_WIDTH-1:0] rd_data_o;
   logic                           rd_ready_i;

   // Operations in file order
   logic                           op_we_q[$];
   logic [mam_pkg::ADDR_WIDTH-1:0] op_addr_q[$];
   logic                           op_burst_q[$];
   int                             op_beats_q[$];
   logic [mam_pkg::SEL_WIDTH-1:0]  op_strb_q[$];
   logic [mam_pkg::DATA_WIDTH-1:0] word_q[$];     // Write data and expected read words

   logic [mam_pkg::DATA_WIDTH-1:0] ref_mem [REF_WORDS];
   int                             word_pos;
   int                             check_count;
   int                             error_count;
   int                             total_beats;
   logic                           stim_loaded = 1'b0;

   tb_clk_gen i_tb_clk_gen (
      .clk_o (clk_i)
   );

   mam_mem_top i_mam_mem_top (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (req_valid_i),
      .req_i       (req_i),
      .req_ready_o (req_ready_o),
      .wr_valid_i  (wr_valid_i),
      .wr_data_i   (wr_data_i),
      .wr_strb_i   (wr_strb_i),
      .wr_ready_o  (wr_ready_o),
      .rd_valid_o  (rd_valid_o),
      .rd_data_o   (rd_data_o),
      .rd_ready_i  (rd_ready_i)
   );

   task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Non-burst requests and bursts of 0 or 1 move one word
   function automatic int beat_count(input logic burst, input int beats);
      return (!burst || beats <= 1) ? 1 : beats;
   endfunction

   function automatic void ref_write(input logic [31:0] addr, input logic [15:0] data,
                                     input logic [1:0] strb);
      int idx;
      idx = int'(addr >> 1);
      if (addr < mam_pkg::MAPPED_LIMIT) begin   // Unmapped writes vanish
         if (strb[0]) begin
            ref_mem[idx][7:0] = data[7:0];
         end
         if (strb[1]) begin
            ref_mem[idx][15:8] = data[15:8];
         end
      end
   endfunction

   function automatic logic [15:0] ref_read(input logic [31:0] addr);
      if (addr < mam_pkg::MAPPED_LIMIT) begin
         return ref_mem[int'(addr >> 1)];
      end
      return mam_pkg::UNMAPPED_DATA;
   endfunction

   task automatic load_stim();
      int          fd;
      int          code;
      int          c;
      int          burst_v;
      int          beats_v;
      int          strb_v;
      int          nbeats;
      logic [7:0]  op_c;
      logic [31:0] addr_v;
      logic [15:0] word_v;
      logic        done;
      fd = $fopen("tb/mam_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file tb/mam_stim.txt");
         error_count++;
      end else begin
         done = 1'b0;
         while (!done) begin
            code = $fscanf(fd, "%s", op_c);
            if (code != 1) begin
               done = 1'b1;                      // End of file
            end else if (op_c == "#") begin
               c = $fgetc(fd);
               while (c != 10 && c != -1) begin
                  c = $fgetc(fd);
               end
            end else if (op_c == "W" || op_c == "R") begin
               code = $fscanf(fd, "%h %d %d %h", addr_v, burst_v, beats_v, strb_v);
               if (code != 4) begin
                  $display("Malformed operation line in the stimulus file");
                  error_count++;
                  done = 1'b1;
               end else begin
                  op_we_q.push_back(op_c == "W");
                  op_addr_q.push_back(addr_v);
                  op_burst_q.push_back(burst_v != 0);
                  op_beats_q.push_back(beats_v);
                  op_strb_q.push_back(strb_v[1:0]);
                  nbeats = beat_count(burst_v != 0, beats_v);
                  total_beats += nbeats;
                  for (int i = 0; i < nbeats; i++) begin
                     code = $fscanf(fd, "%h", word_v);
                     if (code != 1) begin
                        $display("Missing data word in the stimulus file");
                        error_count++;
                     end
                     word_q.push_back(word_v);
                  end
               end
            end else begin
               $display("Unknown operation %s in the stimulus file", op_c);
               error_count++;
               done = 1'b1;
            end
         end
         $fclose(fd);
      end
      stim_loaded = 1'b1;
   endtask

   task automatic random_gap();
      int n;
      n = $urandom % 3;
      repeat (n) @(negedge clk_i);
   endtask

   task automatic wait_idle();
      while (!req_ready_o) @(negedge clk_i);
   endtask

   // Starts on a falling edge and returns on the falling edge after the handshake
   task automatic send_request(input logic we, input logic [31:0] addr, input logic burst,
                               input int beats);
      mam_pkg::mam_req_t req;
      req.we      = we;
      req.addr    = addr;
      req.burst   = burst;
      req.beats   = beats[mam_pkg::BEATS_WIDTH-1:0];
      req_i       = req;
      req_valid_i = 1'b1;
      while (!req_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      req_valid_i = 1'b0;
   endtask

   task automatic push_write_word(input logic [15:0] data, input logic [1:0] strb);
      random_gap();                            // wr_valid_i stays low here
      wr_data_i  = data;
      wr_strb_i  = strb;
      wr_valid_i = 1'b1;
      while (!wr_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      wr_valid_i = 1'b0;
   endtask

   task automatic pull_read_word(output logic [15:0] data);
      random_gap();                            // Back-pressure on the read stream
      rd_ready_i = 1'b1;
      while (!rd_valid_o) @(negedge clk_i);
      data = rd_data_o;
      @(negedge clk_i);
      rd_ready_i = 1'b0;
   endtask

   task automatic run_write(input int n);
      int          nbeats;
      logic [15:0] data;
      logic [31:0] addr;
      nbeats = beat_count(op_burst_q[n], op_beats_q[n]);
      send_request(1'b1, op_addr_q[n], op_burst_q[n], op_beats_q[n]);
      for (int i = 0; i < nbeats; i++) begin
         data = word_q[word_pos];
         word_pos++;
         addr = op_addr_q[n] + 32'(2 * i);
         push_write_word(data, op_strb_q[n]);
         ref_write(addr, data, op_burst_q[n] ? 2'b11 : op_strb_q[n]);  // Bursts write whole words
      end
      wait_idle();
   endtask

   task automatic run_read(input int n);
      int          nbeats;
      logic [15:0] got;
      logic [15:0] exp_file;
      logic [31:0] addr;
      nbeats = beat_count(op_burst_q[n], op_beats_q[n]);
      send_request(1'b0, op_addr_q[n], op_burst_q[n], op_beats_q[n]);
      for (int i = 0; i < nbeats; i++) begin
         pull_read_word(got);
         addr     = op_addr_q[n] + 32'(2 * i);
         exp_file = word_q[word_pos];
         word_pos++;
         check_value($sformatf("read 0x%h against file", addr), got, exp_file);
         check_value($sformatf("read 0x%h against model", addr), got, ref_read(addr));
      end
      wait_idle();
      check_value("rd_valid_o after the last read word", 16'(rd_valid_o), 16'h0);
   endtask

   // Watchdog sized from the beats in the file
   initial begin
      longint limit_ns;
      wait (stim_loaded);
      limit_ns = longint'(total_beats * MAX_CYCLES_PER_BEAT
                          + op_we_q.size() * OP_OVERHEAD_CYCLES + SETUP_CYCLES) * CLK_PERIOD_NS;
      #(limit_ns);
      $display("Timeout: the run did not finish within %0d ns", limit_ns);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      void'($urandom(25));
      rst_i       = 1'b1;
      req_valid_i = 1'b0;
      req_i       = '0;
      wr_valid_i  = 1'b0;
      wr_data_i   = '0;
      wr_strb_i   = '0;
      rd_ready_i  = 1'b0;
      check_count = 0;
      error_count = 0;
      word_pos    = 0;
      total_beats = 0;
      load_stim();
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      check_value("req_ready_o after reset", 16'(req_ready_o), 16'h1);
      check_value("rd_valid_o after reset", 16'(rd_valid_o), 16'h0);
      check_value("wr_ready_o after reset", 16'(wr_ready_o), 16'h0);
      for (int n = 0; n < op_we_q.size(); n++) begin
         if (op_we_q[n]) begin
            run_write(n);
         end else begin
            run_read(n);
         end
      end
      wait_idle();
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* tb/mam_stim.txt */
# op addr burst beats strb words; W lines carry write data, R lines the expected read words
# addr, strb and words in hex, burst and beats in decimal; burst 0 moves one word
W 0000 0 1 3 1234
W 0080 0 1 3 5678
W 0100 0 1 3 9ABC
W 0180 0 1 3 DEF0
R 0000 0 1 0 1234
R 0080 0 1 0 5678
R 0100 0 1 0 9ABC
R 0180 0 1 0 DEF0
W 0010 0 1 3 A1B2
W 0010 0 1 1 00C3
R 0010 0 1 0 A1C3
W 0012 0 1 3 1122
W 0012 0 1 2 3300
R 0012 0 1 0 3322
W 0014 0 1 3 FFFF
W 0014 0 1 0 0000
R 0014 0 1 0 FFFF
W 0078 1 8 3 1001 1002 1003 1004 1005 1006 1007 1008
R 0078 1 8 0 1001 1002 1003 1004 1005 1006 1007 1008
R 0000 0 1 0 1234
W 0140 1 12 3 C000 C001 C002 C003 C004 C005 C006 C007 C008 C009 C00A C00B
R 0140 1 12 0 C000 C001 C002 C003 C004 C005 C006 C007 C008 C009 C00A C00B
W 01F8 1 4 3 A0A0 A1A1 A2A2 A3A3
R 01FC 1 4 0 A2A2 A3A3 DEAD DEAD
W 0200 0 1 3 BEEF
W 0300 1 4 3 1111 2222 3333 4444
W 0380 0 1 3 0055
R 0200 0 1 0 DEAD
R 0300 1 2 0 DEAD DEAD
R 0000 0 1 0 1234
R 0100 0 1 0 9ABC
R 0180 0 1 0 DEF0
R 0010 0 1 0 A1C3
R 0080 1 4 0 1005 1006 1007 1008
R 1000 1 3 0 DEAD DEAD DEAD
R 0140 0 1 0 C000

/* filelist.f */
common/mam_pkg.sv
wb_mem/wb_bank_decoder.sv
wb_mem/wb_sram_bank.sv
wb_mem/wb_resp_merge.sv
hw/mam_wb_master.sv
hw/mam_mem_top.sv
tb/tb_clk_gen.sv
tb/mam_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and fails if the log reports a failure
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module mam_mem_tb \
   -f filelist.f -o Vmam_mem_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Build failed"
   exit 1
fi

./obj_dir/Vmam_mem_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAIL" "$SIM_LOG"; then
   exit 1
fi
exit 0
